//--- rtl/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// data path and byte address width
`define XLEN 32

// shared instruction and data RAM, in 32-bit words
`define MEM_WORDS 256

// word index width, log2 of MEM_WORDS
`define MEM_AW 8

`endif

//--- rtl/isa_pkg.sv
`default_nettype none
`include "core_defs.svh"

package isa_pkg;

    typedef enum logic [3:0] {
        EQ, NE, CS, CC, MI, PL, VS, VC,
        HI, LS, GE, LT, GT, LE, AL, NV
    } cond_e;

    // encodings as seen by the ALU outside
    typedef enum logic [2:0] {
        ADD = 3'b000,
        SUB = 3'b001,
        AND = 3'b010,
        ORR = 3'b011,
        XOR = 3'b111
    } alu_op_e;

    typedef struct packed {
        cond_e       cond;
        logic [6:0]  opcode;
        logic        s;
        logic [3:0]  rn;
        logic [3:0]  rd;
        logic [11:0] imm12;
    } instr_layout;

    typedef struct packed {
        cond_e             cond;
        logic [6:0]        opcode;
        logic              s;
        logic [3:0]        rn;
        logic [3:0]        rd;
        logic [1:0]        shift_op;
        logic [11:0]       imm12;
        logic [`XLEN-1:0]  imm_branch;
        logic              p;
        logic              u;
        logic              w;
        logic [`XLEN-1:0]  pc;
        logic [`XLEN-1:0]  raw;
    } decoded_t;

    typedef struct packed {
        logic [1:0] sel_pc;
        logic       sel_branch_imm;
        logic       sel_a;
        logic       sel_b;
        alu_op_e    alu_op;
        logic       sel_pre_indexed;
        logic       en_status;
        logic [1:0] sel_w_addr1;
        logic       w_en1;
        logic       mem_w_en;
    } ctrl_t;

    // opcode classes
    function automatic logic is_dp(logic [6:0] op);
        return (op[6] == 1'b0) && (op[5:4] != 2'b10);
    endfunction

    function automatic logic is_mem(logic [6:0] op);
        return (op[6:5] == 2'b11) || (op[6:3] == 4'b1000);
    endfunction

    function automatic logic is_branch(logic [6:0] op);
        return op[6:3] == 4'b1001;
    endfunction

endpackage

`default_nettype wire

//--- rtl/bus_pkg.sv
`default_nettype none
`include "core_defs.svh"

package bus_pkg;

    // master to slave, Wishbone classic
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [`XLEN-1:0]  adr;
        logic [`XLEN-1:0]  dat_w;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic              ack;
        logic [`XLEN-1:0]  dat_r;
    } wb_rsp_t;

endpackage

`default_nettype wire

//--- rtl/mem_pipeline_reg.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module mem_pipeline_reg
    import isa_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              fetch_valid,
    input  logic [`XLEN-1:0]  fetch_word,
    input  logic [`XLEN-1:0]  fetch_pc,
    input  logic              fetch_ref,
    input  logic              branch_ref,
    input  logic              stall,
    output decoded_t          instr,
    output logic              instr_valid
);

    instr_layout f;
    decoded_t    next;

    // field split of the incoming word
    always_comb begin
        f = instr_layout'(fetch_word);
        next.cond = f.cond;
        next.opcode = f.opcode;
        next.s = f.s;
        next.rn = f.rn;
        next.rd = f.rd;
        next.shift_op = f.imm12[6:5];
        next.imm12 = f.imm12;
        next.imm_branch = {{(`XLEN-23){fetch_word[20]}}, fetch_word[20:0], 2'b00};
        next.p = f.opcode[2];
        next.u = f.opcode[1];
        next.w = f.opcode[0];
        next.pc = fetch_pc;
        next.raw = fetch_word;
    end

    // a word fetched before the last taken branch is dropped here
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_valid <= 1'b0;
        end else if (!stall) begin
            instr_valid <= fetch_valid && (fetch_ref == branch_ref);
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && fetch_valid) begin
            instr <= next;
        end
    end

endmodule

`default_nettype wire

//--- rtl/mem_ctrl_decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module mem_ctrl_decode
    import isa_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  decoded_t          instr,
    input  logic              instr_valid,
    input  logic [`XLEN-1:0]  status,
    input  logic [`XLEN-1:0]  operand_a,
    output ctrl_t             ctrl,
    output logic              branch_ref,
    output logic              redirect,
    output logic [`XLEN-1:0]  redirect_pc,
    output logic              mem_req
);

    logic branch_ref_q;
    logic n_flag;
    logic z_flag;
    logic c_flag;
    logic v_flag;
    logic cond_ok;
    logic active;

    // NZCV in the top four status bits
    assign {n_flag, z_flag, c_flag, v_flag} = status[`XLEN-1 -: 4];
    assign active = instr_valid && (instr.cond != NV);

    // register-relative branches take the target from rn
    assign redirect_pc = instr.opcode[0] ? operand_a : instr.pc + instr.imm_branch;

    always_comb begin
        case (instr.cond)
            EQ: cond_ok = z_flag;
            NE: cond_ok = ~z_flag;
            CS: cond_ok = c_flag;
            CC: cond_ok = ~c_flag;
            MI: cond_ok = n_flag;
            PL: cond_ok = ~n_flag;
            VS: cond_ok = v_flag;
            VC: cond_ok = ~v_flag;
            HI: cond_ok = c_flag & ~z_flag;
            LS: cond_ok = ~c_flag | z_flag;
            GE: cond_ok = (n_flag == v_flag);
            LT: cond_ok = (n_flag != v_flag);
            GT: cond_ok = ~z_flag & (n_flag == v_flag);
            LE: cond_ok = z_flag | (n_flag != v_flag);
            AL: cond_ok = 1'b1;
            default: cond_ok = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            branch_ref_q <= 1'b0;
        end else begin
            branch_ref_q <= branch_ref;
        end
    end

    always_comb begin
        ctrl = '0;
        branch_ref = branch_ref_q;
        redirect = 1'b0;
        mem_req = 1'b0;
        if (active && is_dp(instr.opcode)) begin
            ctrl.sel_a = ~instr.opcode[3];
            ctrl.sel_b = ~instr.opcode[4];
            case (instr.opcode[2:0])
                3'b000: ctrl.alu_op = ADD;
                3'b001: ctrl.alu_op = SUB;
                3'b010: ctrl.alu_op = SUB;
                3'b011: ctrl.alu_op = AND;
                3'b100: ctrl.alu_op = ORR;
                3'b101: ctrl.alu_op = XOR;
                default: ctrl.alu_op = ADD;
            endcase
            ctrl.en_status = instr.s;
            // compare writes flags only
            ctrl.w_en1 = (instr.opcode[3:0] != 4'b1010);
        end else if (active && is_mem(instr.opcode)) begin
            mem_req = 1'b1;
            ctrl.sel_b = ~instr.opcode[3];
            ctrl.sel_pre_indexed = instr.p;
            ctrl.alu_op = instr.u ? ADD : SUB;
            ctrl.w_en1 = instr.w;
            ctrl.sel_w_addr1 = instr.w ? 2'b10 : 2'b00;
            ctrl.mem_w_en = instr.opcode[4];
        end else if (active && is_branch(instr.opcode)) begin
            ctrl.sel_a = instr.opcode[0];
            ctrl.sel_b = ~instr.opcode[0];
            ctrl.sel_branch_imm = ~instr.opcode[0];
            if (cond_ok) begin
                ctrl.sel_pc = 2'b11;
                branch_ref = ~branch_ref_q;
                redirect = 1'b1;
            end
            // link goes to the second write address
            if (instr.opcode[1]) begin
                ctrl.sel_w_addr1 = 2'b01;
                ctrl.w_en1 = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module fetch_unit
    import bus_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              branch_ref,
    input  logic              redirect,
    input  logic [`XLEN-1:0]  redirect_pc,
    input  logic              stall,
    input  wb_rsp_t           rsp,
    output wb_req_t           req,
    output logic              fetch_valid,
    output logic [`XLEN-1:0]  fetch_word,
    output logic [`XLEN-1:0]  fetch_pc,
    output logic              fetch_ref
);

    logic             busy_q;
    logic             have_q;
    logic             discard_q;
    logic             ref_q;
    logic [`XLEN-1:0] pc_q;
    logic [`XLEN-1:0] adr_q;
    logic [`XLEN-1:0] word_q;
    logic             ack_in;
    logic             issue;

    assign ack_in = busy_q & rsp.ack;
    // one word in flight or waiting, never both
    assign issue = ~busy_q & ~have_q & ~stall & ~redirect;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            have_q <= 1'b0;
            discard_q <= 1'b0;
            ref_q <= 1'b0;
            pc_q <= '0;
            adr_q <= '0;
        end else begin
            if (have_q && !stall) begin
                have_q <= 1'b0;
            end
            if (issue) begin
                busy_q <= 1'b1;
                adr_q <= pc_q;
                ref_q <= branch_ref;
            end
            if (ack_in) begin
                busy_q <= 1'b0;
                discard_q <= 1'b0;
                if (!discard_q && !redirect) begin
                    have_q <= 1'b1;
                    pc_q <= adr_q + `XLEN'd4;
                end
            end
            // keep the bus cycle open but drop its data
            if (redirect) begin
                pc_q <= redirect_pc;
                have_q <= 1'b0;
                if (busy_q && !rsp.ack) begin
                    discard_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ack_in) begin
            word_q <= rsp.dat_r;
        end
    end

    assign req = '{cyc: busy_q, stb: busy_q, we: 1'b0, adr: adr_q, dat_w: '0};
    assign fetch_valid = have_q;
    assign fetch_word = word_q;
    assign fetch_pc = adr_q;
    assign fetch_ref = ref_q;

endmodule

`default_nettype wire

//--- rtl/data_port.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module data_port
    import isa_pkg::*, bus_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              mem_req,
    input  decoded_t          instr,
    input  ctrl_t             ctrl,
    input  logic [`XLEN-1:0]  operand_a,
    input  logic [`XLEN-1:0]  store_data,
    input  wb_rsp_t           rsp,
    output wb_req_t           req,
    output logic              stall,
    output logic              load_valid,
    output logic [`XLEN-1:0]  load_data,
    output logic              store_done
);

    logic             busy_q;
    logic             done_q;
    logic             we_q;
    logic [`XLEN-1:0] adr_q;
    logic [`XLEN-1:0] dat_q;
    logic [`XLEN-1:0] load_q;
    logic [`XLEN-1:0] offset;
    logic [`XLEN-1:0] ea;
    logic             start;

    // register offsets come from the ALU outside, none here
    assign offset = ctrl.sel_b ? {{(`XLEN-12){1'b0}}, instr.imm12} : '0;

    always_comb begin
        if (!ctrl.sel_pre_indexed) begin
            ea = operand_a;
        end else if (instr.u) begin
            ea = operand_a + offset;
        end else begin
            ea = operand_a - offset;
        end
    end

    assign start = mem_req & ~busy_q & ~done_q;
    // released in the result cycle so the instruction retires
    assign stall = mem_req & ~done_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            we_q <= 1'b0;
        end else begin
            done_q <= busy_q & rsp.ack;
            if (busy_q && rsp.ack) begin
                busy_q <= 1'b0;
            end else if (start) begin
                busy_q <= 1'b1;
                we_q <= ctrl.mem_w_en;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            adr_q <= ea;
            dat_q <= store_data;
        end
        if (busy_q && rsp.ack) begin
            load_q <= rsp.dat_r;
        end
    end

    assign req = '{cyc: busy_q, stb: busy_q, we: we_q, adr: adr_q, dat_w: dat_q};
    assign load_valid = done_q & ~we_q;
    assign store_done = done_q & we_q;
    assign load_data = load_q;

endmodule

`default_nettype wire

//--- rtl/wb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter
    import bus_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  wb_req_t host_req,
    input  wb_req_t data_req,
    input  wb_req_t fetch_req,
    input  wb_rsp_t slv_rsp,
    output wb_rsp_t host_rsp,
    output wb_rsp_t data_rsp,
    output wb_rsp_t fetch_rsp,
    output wb_req_t slv_req
);

    typedef enum logic [1:0] {
        GNT_NONE,
        GNT_HOST,
        GNT_DATA,
        GNT_FETCH
    } gnt_e;

    gnt_e gnt_q;
    gnt_e pick;
    gnt_e sel;
    logic hold;

    always_comb begin
        if (host_req.cyc) begin
            pick = GNT_HOST;
        end else if (data_req.cyc) begin
            pick = GNT_DATA;
        end else if (fetch_req.cyc) begin
            pick = GNT_FETCH;
        end else begin
            pick = GNT_NONE;
        end
        // owner keeps the bus until its cyc drops
        case (gnt_q)
            GNT_HOST: hold = host_req.cyc;
            GNT_DATA: hold = data_req.cyc;
            GNT_FETCH: hold = fetch_req.cyc;
            default: hold = 1'b0;
        endcase
        sel = hold ? gnt_q : pick;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gnt_q <= GNT_NONE;
        end else begin
            gnt_q <= sel;
        end
    end

    always_comb begin
        slv_req = '0;
        host_rsp = '{ack: 1'b0, dat_r: slv_rsp.dat_r};
        data_rsp = '{ack: 1'b0, dat_r: slv_rsp.dat_r};
        fetch_rsp = '{ack: 1'b0, dat_r: slv_rsp.dat_r};
        case (sel)
            GNT_HOST: begin
                slv_req = host_req;
                host_rsp.ack = slv_rsp.ack;
            end
            GNT_DATA: begin
                slv_req = data_req;
                data_rsp.ack = slv_rsp.ack;
            end
            GNT_FETCH: begin
                slv_req = fetch_req;
                fetch_rsp.ack = slv_rsp.ack;
            end
            default: begin
                slv_req = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/wb_ram.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module wb_ram
    import bus_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  wb_req_t req,
    output wb_rsp_t rsp
);

    logic [`XLEN-1:0]  mem [`MEM_WORDS];
    logic [`MEM_AW-1:0] idx;
    logic              ack_q;
    logic [`XLEN-1:0]  rdata_q;
    logic              strobe;

    // byte address in, word index out
    assign idx = req.adr[`MEM_AW+1:2];
    // one ack per strobe, never back to back
    assign strobe = req.cyc & req.stb & ~ack_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= strobe;
        end
    end

    always_ff @(posedge clk) begin
        if (strobe) begin
            rdata_q <= mem[idx];
        end
        if (ack_q && req.cyc && req.stb && req.we) begin
            mem[idx] <= req.dat_w;
        end
    end

    assign rsp = '{ack: ack_q, dat_r: rdata_q};

endmodule

`default_nettype wire

//--- rtl/mem_stage_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module mem_stage_top
    import isa_pkg::*, bus_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  wb_req_t           host_req,
    input  logic [`XLEN-1:0]  status,
    input  logic [`XLEN-1:0]  operand_a,
    input  logic [`XLEN-1:0]  store_data,
    output wb_rsp_t           host_rsp,
    output ctrl_t             ctrl,
    output decoded_t          decoded,
    output logic              out_valid,
    output logic              branch_ref,
    output logic              load_valid,
    output logic [`XLEN-1:0]  load_data,
    output logic              store_done
);

    wb_req_t          data_req;
    wb_req_t          fetch_req;
    wb_req_t          slv_req;
    wb_rsp_t          data_rsp;
    wb_rsp_t          fetch_rsp;
    wb_rsp_t          slv_rsp;
    logic             fetch_valid;
    logic             fetch_ref;
    logic             instr_valid;
    logic             redirect;
    logic             mem_req;
    logic             stall;
    logic [`XLEN-1:0] fetch_word;
    logic [`XLEN-1:0] fetch_pc;
    logic [`XLEN-1:0] redirect_pc;

    // retire marker, held back while a load or store is pending
    assign out_valid = instr_valid & ~stall;

    fetch_unit u_fetch (
        .clk, .rst_n, .branch_ref, .redirect, .redirect_pc, .stall,
        .rsp(fetch_rsp), .req(fetch_req),
        .fetch_valid, .fetch_word, .fetch_pc, .fetch_ref
    );

    mem_pipeline_reg u_pipe (
        .clk, .rst_n, .fetch_valid, .fetch_word, .fetch_pc, .fetch_ref,
        .branch_ref, .stall, .instr(decoded), .instr_valid
    );

    mem_ctrl_decode u_ctrl (
        .clk, .rst_n, .instr(decoded), .instr_valid, .status, .operand_a,
        .ctrl, .branch_ref, .redirect, .redirect_pc, .mem_req
    );

    data_port u_data (
        .clk, .rst_n, .mem_req, .instr(decoded), .ctrl, .operand_a, .store_data,
        .rsp(data_rsp), .req(data_req), .stall, .load_valid, .load_data, .store_done
    );

    wb_arbiter u_arb (
        .clk, .rst_n, .host_req, .data_req, .fetch_req, .slv_rsp,
        .host_rsp, .data_rsp, .fetch_rsp, .slv_req
    );

    wb_ram u_ram (
        .clk, .rst_n, .req(slv_req), .rsp(slv_rsp)
    );

endmodule

`default_nettype wire

//--- tb/tb_mem_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_defs.svh"

module tb_mem_stage
    import isa_pkg::*, bus_pkg::*;
;

    localparam int TIMEOUT = 4000;
    // program layout, byte addresses
    localparam logic [31:0] STR_PC = 32'hb0;
    localparam logic [31:0] LDR_PC = 32'hb4;
    localparam logic [31:0] LOOP_PC = 32'hb8;
    localparam logic [31:0] BASE = 32'h300;
    localparam logic [31:0] SCRATCH = 32'h380;

    logic              clk;
    logic              rst_n;
    wb_req_t           host_req;
    logic [`XLEN-1:0]  status;
    logic [`XLEN-1:0]  operand_a;
    logic [`XLEN-1:0]  store_data;
    wb_rsp_t           host_rsp;
    ctrl_t             ctrl;
    decoded_t          decoded;
    logic              out_valid;
    logic              branch_ref;
    logic              load_valid;
    logic [`XLEN-1:0]  load_data;
    logic              store_done;

    integer            seed = 32'h8279_507e;
    logic [31:0]       image [`MEM_WORDS];
    logic              checking;
    logic              loop_seen;

    mem_stage_top u_dut (
        .clk, .rst_n, .host_req, .status, .operand_a, .store_data,
        .host_rsp, .ctrl, .decoded, .out_valid, .branch_ref,
        .load_valid, .load_data, .store_done
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // fresh NZCV every cycle
    initial begin
        status = '0;
        forever begin
            @(posedge clk);
            status <= $random(seed);
        end
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_ctrl(input string name, input ctrl_t got, input ctrl_t exp);
        if (got !== exp) begin
            fail_now($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input logic [`XLEN-1:0] got,
                              input logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_now($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    // NZCV sits in status[31:28]
    function automatic logic cond_holds(input logic [3:0] cd, input logic [31:0] st);
        logic n;
        logic z;
        logic c;
        logic v;
        {n, z, c, v} = st[31:28];
        case (cd)
            4'h0: return z;
            4'h1: return !z;
            4'h2: return c;
            4'h3: return !c;
            4'h4: return n;
            4'h5: return !n;
            4'h6: return v;
            4'h7: return !v;
            4'h8: return c && !z;
            4'h9: return !c || z;
            4'ha: return n == v;
            4'hb: return n != v;
            4'hc: return !z && (n == v);
            4'hd: return z || (n != v);
            4'he: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic ctrl_t expect_ctrl(input logic [31:0] w, input logic [31:0] st);
        ctrl_t c;
        logic [6:0] op;
        c = '0;
        op = w[27:21];
        if (w[31:28] == 4'hf) begin
            return c;
        end
        if (!op[6] && op[5:4] != 2'b10) begin
            c.sel_a = !op[3];
            c.sel_b = !op[4];
            case (op[2:0])
                3'b001, 3'b010: c.alu_op = SUB;
                3'b011: c.alu_op = AND;
                3'b100: c.alu_op = ORR;
                3'b101: c.alu_op = XOR;
                default: c.alu_op = ADD;
            endcase
            c.en_status = w[20];
            c.w_en1 = (op[3:0] != 4'b1010);
        end else if (op[6:5] == 2'b11 || op[6:3] == 4'b1000) begin
            c.sel_b = !op[3];
            c.sel_pre_indexed = op[2];
            c.alu_op = op[1] ? ADD : SUB;
            c.w_en1 = op[0];
            c.sel_w_addr1 = op[0] ? 2'b10 : 2'b00;
            c.mem_w_en = op[4];
        end else if (op[6:3] == 4'b1001) begin
            c.sel_a = op[0];
            c.sel_b = !op[0];
            c.sel_branch_imm = !op[0];
            if (cond_holds(w[31:28], st)) begin
                c.sel_pc = 2'b11;
            end
            if (op[1]) begin
                c.sel_w_addr1 = 2'b01;
                c.w_en1 = 1'b1;
            end
        end
        return c;
    endfunction

    task automatic host_access(input logic we, input logic [31:0] adr,
                               input logic [31:0] wdat, output logic [31:0] rdat);
        logic got;
        got = 1'b0;
        @(posedge clk);
        host_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: wdat};
        for (int n = 0; n < TIMEOUT && !got; n++) begin
            @(posedge clk);
            got = host_rsp.ack;
        end
        if (!got) begin
            fail_now("host access got no acknowledge before the timeout");
        end
        rdat = host_rsp.dat_r;
        host_req <= '0;
    endtask

    task automatic load_word(input logic [31:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        image[adr[`MEM_AW+1:2]] = dat;
        host_access(1'b1, adr, dat, unused);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    // reference model follows the program flow and compares each retire
    initial begin
        logic [31:0] exp_pc;
        logic [31:0] poison_pc;
        logic [31:0] w;
        logic [31:0] ea;
        logic        exp_ref;
        logic        armed;
        logic        is_ldst;
        exp_pc = '0;
        exp_ref = 1'b0;
        armed = 1'b0;
        poison_pc = '0;
        forever begin
            @(posedge clk);
            if (checking && out_valid) begin
                w = image[exp_pc[`MEM_AW+1:2]];
                if (armed && decoded.pc == poison_pc) begin
                    fail_now("the word after a taken branch retired");
                end
                armed = 1'b0;
                check_word("decoded.pc", decoded.pc, exp_pc);
                check_word("decoded.raw", decoded.raw, w);
                check_word("decoded.cond/opcode/s/rn",
                           32'({decoded.cond, decoded.opcode, decoded.s, decoded.rn}),
                           32'(w[31:16]));
                check_word("decoded.rd", 32'(decoded.rd), 32'(w[15:12]));
                check_word("decoded.imm12", 32'(decoded.imm12), 32'(w[11:0]));
                check_word("decoded.shift_op", 32'(decoded.shift_op), 32'(w[6:5]));
                check_word("decoded.p/u/w", 32'({decoded.p, decoded.u, decoded.w}),
                           32'(w[23:21]));
                check_word("decoded.imm_branch", decoded.imm_branch,
                           {{9{w[20]}}, w[20:0], 2'b00});
                check_ctrl("ctrl", ctrl, expect_ctrl(w, status));
                is_ldst = (w[31:28] != 4'hf) && (w[27:26] == 2'b11 || w[27:24] == 4'b1000);
                check_flag("store_done", store_done, is_ldst && w[25]);
                check_flag("load_valid", load_valid, is_ldst && !w[25]);
                if (is_ldst && !w[25]) begin
                    ea = w[23] ? operand_a + (w[22] ? 32'(w[11:0]) : -32'(w[11:0]))
                               : operand_a;
                    check_word("load_data", load_data, image[ea[`MEM_AW+1:2]]);
                end
                if (w[27:24] == 4'b1001 && cond_holds(w[31:28], status)) begin
                    exp_ref = !exp_ref;
                    poison_pc = exp_pc + 32'd4;
                    armed = 1'b1;
                    if (exp_pc == LOOP_PC) begin
                        loop_seen = 1'b1;
                    end
                    exp_pc = exp_pc + {{9{w[20]}}, w[20:0], 2'b00};
                end else begin
                    exp_pc = exp_pc + 32'd4;
                end
                check_flag("branch_ref", branch_ref, exp_ref);
            end
        end
    end

    initial begin
        logic [31:0] w;
        logic [31:0] rd;
        logic [31:0] scratch [4];
        logic [6:0]  op;
        int          idx;
        rst_n = 1'b0;
        host_req = '0;
        operand_a = BASE;
        store_data = $random(seed);
        checking = 1'b0;
        loop_seen = 1'b0;
        for (int i = 0; i < `MEM_WORDS; i++) begin
            image[i] = '0;
        end
        apply_reset();
        // spin loop first, so the fetch never runs into the data area
        load_word(LOOP_PC, {4'he, 7'b1001000, 21'd0});
        for (idx = 0; idx < 12; idx++) begin
            op = 7'($random(seed)) & 7'h3f;
            if (op[5:4] == 2'b10) begin
                op[5:4] = 2'b00;
            end
            w = $random(seed);
            load_word(32'(idx * 4), {w[31:28], op, w[20:0]});
        end
        // each cond: branch over one word, link on odd codes
        for (int c = 0; c < 16; c++) begin
            op = (c % 2) ? 7'b1001010 : 7'b1001000;
            load_word(32'(idx * 4), {4'(c), op, 21'd2});
            w = $random(seed);
            load_word(32'(idx * 4 + 4), {4'he, 7'b0000000, w[20:0]});
            idx = idx + 2;
        end
        load_word(STR_PC, {4'he, 7'b1110110, 1'b0, 4'd1, 4'd2, 12'h010});
        load_word(LDR_PC, {4'he, 7'b1100110, 1'b0, 4'd1, 4'd3, 12'h020});
        load_word(BASE + 32'h20, $random(seed));
        image[(BASE + 32'h10) >> 2] = store_data;
        for (int i = 0; i < 4; i++) begin
            scratch[i] = $random(seed);
            load_word(SCRATCH + 32'(i * 8), scratch[i]);
        end
        for (int i = 0; i < 4; i++) begin
            host_access(1'b0, SCRATCH + 32'(i * 8), '0, rd);
            check_word("host read", rd, scratch[i]);
        end
        // restart from pc 0 on the loaded program
        apply_reset();
        checking = 1'b1;
        // store target holds something else until the store runs
        host_access(1'b1, BASE + 32'h10, ~store_data, rd);
        for (int n = 0; n < TIMEOUT && !loop_seen; n++) begin
            @(posedge clk);
        end
        if (!loop_seen) begin
            fail_now("program never reached its final loop before the timeout");
        end
        host_access(1'b0, BASE + 32'h10, '0, rd);
        check_word("stored word", rd, store_data);
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+rtl
rtl/isa_pkg.sv
rtl/bus_pkg.sv
rtl/mem_pipeline_reg.sv
rtl/mem_ctrl_decode.sv
rtl/fetch_unit.sv
rtl/data_port.sv
rtl/wb_arbiter.sv
rtl/wb_ram.sv
rtl/mem_stage_top.sv
tb/tb_mem_stage.sv

//--- Makefile
VERILATOR ?= verilator
FLIST     ?= vlog.f
TB_TOP    ?= tb_mem_stage
RTL_TOP   ?= mem_stage_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary --timing -f $(FLIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
